// ==== verilog/soc_bus_pkg.sv ====
// bus structs for the tcdm masters, memory targets, apb port and debug peripheral bus
package soc_bus_pkg;

  // number of tcdm masters, index 0 is fc data and wins every conflict
  localparam int unsigned N_MASTERS = 2;
  localparam int unsigned MST_W     = $clog2(N_MASTERS);

  // tcdm master request, held until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } tcdm_req_t;

  // gnt is combinational, r_valid one cycle after gnt
  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_rdata;
  } tcdm_rsp_t;

  // request to one memory target, word index already decoded
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [7:0]  idx;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // bridge to debug register request
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [11:0] addr;
    logic [31:0] wdata;
  } per_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_rdata;
  } per_rsp_t;

endpackage

// ==== verilog/soc_map_pkg.sv ====
// address map, memory geometry, boot image and debug register layout of the soc domain
package soc_map_pkg;

  // ********************************************************
  // l2 and rom map
  // ********************************************************
  localparam logic [31:0] L2_BASE       = 32'h1C00_0000;
  localparam int unsigned NB_L2_BANKS   = 4;
  localparam int unsigned BANK_W        = $clog2(NB_L2_BANKS);
  localparam int unsigned L2_BANK_WORDS = 256;
  localparam int unsigned L2_SIZE       = NB_L2_BANKS * L2_BANK_WORDS * 4;

  localparam logic [31:0] ROM_BASE  = 32'h1A00_0000;
  localparam int unsigned ROM_WORDS = 16;

  // decoded target code, banks first, then rom, then unmapped
  localparam int unsigned        TGT_W    = 3;
  localparam logic [TGT_W-1:0]   TGT_ROM  = TGT_W'(NB_L2_BANKS);
  localparam logic [TGT_W-1:0]   TGT_NONE = TGT_W'(NB_L2_BANKS + 1);

  localparam logic [31:0] BOOT_IMAGE [ROM_WORDS] = '{
    32'h1C00_0537, 32'h0005_0513, 32'h0000_0593, 32'h0000_0613,
    32'h00B5_2023, 32'h0045_0513, 32'h0015_8593, 32'hFEC5_9AE3,
    32'h1000_0073, 32'h0000_0013, 32'h0000_0013, 32'hFF5F_F06F,
    32'hCAFE_F00D, 32'h1234_5678, 32'h8765_4321, 32'hA5A5_5A5A
  };

  localparam logic [31:0] ERR_RDATA = 32'hBADA_CCE5;

  // ********************************************************
  // debug registers
  // ********************************************************
  // dmcontrol bit 0 dmactive, bit 1 ndmreset, bit 2 haltreq
  localparam logic [11:0] DBG_DMCONTROL_OFFS = 12'h000;
  localparam logic [11:0] DBG_DATA0_OFFS     = 12'h004;
  localparam logic [11:0] DBG_DATA1_OFFS     = 12'h008;
  localparam logic [11:0] DBG_HARTINFO_OFFS  = 12'h00C;

  // nscratch 2, dataaccess 1, datasize 2, dataaddr 0x380
  localparam logic [31:0] HARTINFO_VALUE = {8'h00, 4'd2, 3'b000, 1'b1, 4'd2, 12'h380};

endpackage

// ==== verilog/soc_interconnect.sv ====
// tcdm crossbar from the fc and debug masters to interleaved l2 banks and the boot rom
`timescale 1ns/1ns

module soc_interconnect (
  input  logic                                                  s_soc_clk,
  input  logic                                                  s_soc_rstn,
  input  soc_bus_pkg::tcdm_req_t [soc_bus_pkg::N_MASTERS-1:0]   mst_req_i,
  output soc_bus_pkg::tcdm_rsp_t [soc_bus_pkg::N_MASTERS-1:0]   mst_rsp_o,
  output soc_bus_pkg::mem_req_t  [soc_map_pkg::NB_L2_BANKS-1:0] l2_req_o,
  input  logic [soc_map_pkg::NB_L2_BANKS-1:0][31:0]             l2_rdata_i,
  output soc_bus_pkg::mem_req_t                                 rom_req_o,
  input  logic [31:0]                                           rom_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  // decoded target per master
  logic [N_MASTERS-1:0][TGT_W-1:0] tgt;
  logic [N_MASTERS-1:0]            gnt;
  // one bit and one owner per real target, rom at the top
  logic [NB_L2_BANKS:0]            busy;
  logic [NB_L2_BANKS:0][MST_W-1:0] owner;

  // granted target, kept for the response cycle
  logic [N_MASTERS-1:0][TGT_W-1:0] tgt_q;
  logic [N_MASTERS-1:0]            rvalid_q;

  // banks interleave on word address bits
  function automatic logic [TGT_W-1:0] decode_tgt(input logic [31:0] addr);
    logic [31:0] l2_off;
    logic [31:0] rom_off;
    l2_off  = addr - L2_BASE;
    rom_off = addr - ROM_BASE;
    if (l2_off < L2_SIZE) begin
      decode_tgt = TGT_W'(addr[BANK_W+1:2]);
    end else if (rom_off < ROM_WORDS * 4) begin
      decode_tgt = TGT_ROM;
    end else begin
      decode_tgt = TGT_NONE;
    end
  endfunction

  // ********************************************************
  // fixed priority arbitration
  // ********************************************************
  always_comb begin
    busy  = '0;
    owner = '0;
    gnt   = '0;
    // lowest index claims a target first
    for (int m = 0; m < N_MASTERS; m++) begin
      tgt[m] = decode_tgt(mst_req_i[m].addr);
      if (mst_req_i[m].req) begin
        if (tgt[m] == TGT_NONE) begin
          // nothing to share, always granted
          gnt[m] = 1'b1;
        end else if (!busy[tgt[m]]) begin
          busy[tgt[m]]  = 1'b1;
          owner[tgt[m]] = MST_W'(m);
          gnt[m]        = 1'b1;
        end
      end
    end
  end

  // winner's request to every target
  always_comb begin
    for (int b = 0; b < NB_L2_BANKS; b++) begin
      l2_req_o[b].req   = busy[b];
      l2_req_o[b].we    = mst_req_i[owner[b]].we;
      l2_req_o[b].be    = mst_req_i[owner[b]].be;
      l2_req_o[b].idx   = mst_req_i[owner[b]].addr[BANK_W+2 +: 8];
      l2_req_o[b].wdata = mst_req_i[owner[b]].wdata;
    end
    rom_req_o.req   = busy[TGT_ROM];
    rom_req_o.we    = mst_req_i[owner[TGT_ROM]].we;
    rom_req_o.be    = mst_req_i[owner[TGT_ROM]].be;
    rom_req_o.idx   = {4'b0, mst_req_i[owner[TGT_ROM]].addr[5:2]};
    rom_req_o.wdata = mst_req_i[owner[TGT_ROM]].wdata;
  end

  // ********************************************************
  // response routing
  // ********************************************************
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      rvalid_q <= '0;
      tgt_q    <= {N_MASTERS{TGT_NONE}};
    end else begin
      rvalid_q <= gnt;
      for (int m = 0; m < N_MASTERS; m++) begin
        if (gnt[m]) begin
          tgt_q[m] <= tgt[m];
        end
      end
    end
  end

  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      mst_rsp_o[m].gnt     = gnt[m];
      mst_rsp_o[m].r_valid = rvalid_q[m];
      if (tgt_q[m] < TGT_ROM) begin
        mst_rsp_o[m].r_rdata = l2_rdata_i[tgt_q[m][BANK_W-1:0]];
      end else if (tgt_q[m] == TGT_ROM) begin
        mst_rsp_o[m].r_rdata = rom_rdata_i;
      end else begin
        // unmapped reads see the error pattern
        mst_rsp_o[m].r_rdata = ERR_RDATA;
      end
    end
  end

endmodule

// ==== verilog/l2_ram_bank.sv ====
// one word-wide l2 bank with byte enables, read data ready the cycle after the request
`timescale 1ns/1ns

module l2_ram_bank (
  input  logic                  s_soc_clk,
  input  soc_bus_pkg::mem_req_t mem_req_i,
  output logic [31:0]           rdata_o
);
  import soc_map_pkg::*;

  logic [31:0] mem [L2_BANK_WORDS];

  always_ff @(posedge s_soc_clk) begin
    if (mem_req_i.req) begin
      if (mem_req_i.we) begin
        // only enabled lanes change
        for (int b = 0; b < 4; b++) begin
          if (mem_req_i.be[b]) begin
            mem[mem_req_i.idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[mem_req_i.idx];
      end
    end
  end

endmodule

// ==== verilog/boot_rom.sv ====
// boot image rom on the memory bus, reads registered and writes dropped
`timescale 1ns/1ns

module boot_rom (
  input  logic                  s_soc_clk,
  input  soc_bus_pkg::mem_req_t mem_req_i,
  output logic [31:0]           rdata_o
);
  import soc_map_pkg::*;

  localparam int unsigned ROM_IDX_W = $clog2(ROM_WORDS);

  logic [ROM_IDX_W-1:0] rom_idx;

  // upper index bits are zero from the decoder
  assign rom_idx = mem_req_i.idx[ROM_IDX_W-1:0];

  // a write still gets r_valid from the interconnect, data unchanged
  always_ff @(posedge s_soc_clk) begin
    if (mem_req_i.req && !mem_req_i.we) begin
      rdata_o <= BOOT_IMAGE[rom_idx];
    end
  end

endmodule

// ==== verilog/apb2per.sv ====
// apb slave that turns each access phase into one peripheral request with a one-cycle reply
`timescale 1ns/1ns

module apb2per (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_bus_pkg::apb_req_t apb_req_i,
  output soc_bus_pkg::apb_rsp_t apb_rsp_o,
  output soc_bus_pkg::per_req_t per_req_o,
  input  soc_bus_pkg::per_rsp_t per_rsp_i
);

  logic access;
  // request already sent in this access phase
  logic issued_q;

  assign access = apb_req_i.psel && apb_req_i.penable;

  // ********************************************************
  // request side
  // ********************************************************
  // first access cycle only, apb has no byte strobes here
  assign per_req_o.req   = access && !issued_q;
  assign per_req_o.we    = apb_req_i.pwrite;
  assign per_req_o.be    = 4'hF;
  assign per_req_o.addr  = apb_req_i.paddr;
  assign per_req_o.wdata = apb_req_i.pwdata;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      issued_q <= 1'b0;
    end else if (!access) begin
      // setup or idle ends the phase
      issued_q <= 1'b0;
    end else if (per_req_o.req && per_rsp_i.gnt) begin
      issued_q <= 1'b1;
    end
  end

  // ********************************************************
  // response side
  // ********************************************************
  // pready rides on r_valid, one cycle after grant
  assign apb_rsp_o.pready  = per_rsp_i.r_valid;
  assign apb_rsp_o.prdata  = per_rsp_i.r_rdata;
  assign apb_rsp_o.pslverr = 1'b0;

endmodule

// ==== verilog/debug_regs.sv ====
// debug control, scratch and hartinfo registers behind the peripheral bus
`timescale 1ns/1ns

module debug_regs (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_bus_pkg::per_req_t per_req_i,
  output soc_bus_pkg::per_rsp_t per_rsp_o,
  output logic                  dmactive_o,
  output logic                  ndmreset_o,
  output logic                  debug_req_o
);
  import soc_map_pkg::*;

  logic        dmactive_q;
  logic        ndmreset_q;
  logic        haltreq_q;
  logic [31:0] data0_q;
  logic [31:0] data1_q;
  logic        wr;
  logic        ctrl_ok;
  logic [31:0] rdata_d;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  function automatic logic [31:0] merge_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr = per_req_i.req && per_req_i.we;
  // control bits need an active or activating dm
  assign ctrl_ok = dmactive_q || per_req_i.wdata[0];

  // ********************************************************
  // register writes
  // ********************************************************
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      data0_q    <= '0;
      data1_q    <= '0;
    end else if (wr) begin
      case (per_req_i.addr)
        DBG_DMCONTROL_OFFS: begin
          // all three bits live in byte 0
          if (per_req_i.be[0]) begin
            dmactive_q <= per_req_i.wdata[0];
            if (ctrl_ok) begin
              ndmreset_q <= per_req_i.wdata[1];
              haltreq_q  <= per_req_i.wdata[2];
            end
          end
        end
        DBG_DATA0_OFFS: data0_q <= merge_be(data0_q, per_req_i.wdata, per_req_i.be);
        DBG_DATA1_OFFS: data1_q <= merge_be(data1_q, per_req_i.wdata, per_req_i.be);
        default: ;
      endcase
    end
  end

  // ********************************************************
  // read path
  // ********************************************************
  always_comb begin
    case (per_req_i.addr)
      DBG_DMCONTROL_OFFS: rdata_d = {29'b0, haltreq_q, ndmreset_q, dmactive_q};
      DBG_DATA0_OFFS:     rdata_d = data0_q;
      DBG_DATA1_OFFS:     rdata_d = data1_q;
      DBG_HARTINFO_OFFS:  rdata_d = HARTINFO_VALUE;
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= per_req_i.req;
    end
  end

  // read data captured with the grant
  always_ff @(posedge s_soc_clk) begin
    if (per_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  // grant always same cycle
  assign per_rsp_o.gnt     = per_req_i.req;
  assign per_rsp_o.r_valid = rvalid_q;
  assign per_rsp_o.r_rdata = rdata_q;

  assign dmactive_o  = dmactive_q;
  assign ndmreset_o  = ndmreset_q;
  assign debug_req_o = haltreq_q;

endmodule

// ==== verilog/soc_domain.sv ====
// soc memory and debug domain top, wires the interconnect, l2, rom, apb bridge and debug regs
`timescale 1ns/1ns

module soc_domain (
  input  logic                   s_soc_clk,
  input  logic                   s_soc_rstn,
  input  soc_bus_pkg::tcdm_req_t fc_req_i,
  input  soc_bus_pkg::tcdm_req_t dbg_req_i,
  output soc_bus_pkg::tcdm_rsp_t fc_rsp_o,
  output soc_bus_pkg::tcdm_rsp_t dbg_rsp_o,
  input  soc_bus_pkg::apb_req_t  apb_req_i,
  output soc_bus_pkg::apb_rsp_t  apb_rsp_o,
  output logic                   dmactive_o,
  output logic                   ndmreset_o,
  output logic                   debug_req_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  tcdm_req_t [N_MASTERS-1:0]         mst_req;
  tcdm_rsp_t [N_MASTERS-1:0]         mst_rsp;
  mem_req_t  [NB_L2_BANKS-1:0]       l2_req;
  logic      [NB_L2_BANKS-1:0][31:0] l2_rdata;
  mem_req_t                          rom_req;
  logic      [31:0]                  rom_rdata;
  per_req_t                          per_req;
  per_rsp_t                          per_rsp;

  // master 0 is fc data and has priority
  assign mst_req[0] = fc_req_i;
  assign mst_req[1] = dbg_req_i;
  assign fc_rsp_o   = mst_rsp[0];
  assign dbg_rsp_o  = mst_rsp[1];

  // ********************************************************
  // memory side
  // ********************************************************
  soc_interconnect soc_interconnect_i (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .mst_req_i   (mst_req),
    .mst_rsp_o   (mst_rsp),
    .l2_req_o    (l2_req),
    .l2_rdata_i  (l2_rdata),
    .rom_req_o   (rom_req),
    .rom_rdata_i (rom_rdata)
  );

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_l2_bank
    l2_ram_bank l2_ram_bank_i (
      .s_soc_clk (s_soc_clk),
      .mem_req_i (l2_req[b]),
      .rdata_o   (l2_rdata[b])
    );
  end

  boot_rom boot_rom_i (
    .s_soc_clk (s_soc_clk),
    .mem_req_i (rom_req),
    .rdata_o   (rom_rdata)
  );

  // ********************************************************
  // debug side
  // ********************************************************
  apb2per apb2per_i (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .per_req_o  (per_req),
    .per_rsp_i  (per_rsp)
  );

  debug_regs debug_regs_i (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .per_req_i   (per_req),
    .per_rsp_o   (per_rsp),
    .dmactive_o  (dmactive_o),
    .ndmreset_o  (ndmreset_o),
    .debug_req_o (debug_req_o)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset source, drives the soc clock and holds reset low at start
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  localparam int unsigned PERIOD_NS    = 8;
  localparam int unsigned RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // three rising edges in reset, release just after the last one
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule

// ==== sim/tb_soc_domain.sv ====
// directed testbench for the soc domain that the Makefile builds from files.f and runs
`timescale 1ns/1ns

module tb_soc_domain;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  // tests need under 200 cycles so the limit leaves a wide margin
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  // bound on any single handshake wait
  localparam int unsigned WAIT_MAX       = 16;

  logic      s_soc_clk;
  logic      s_soc_rstn;
  tcdm_req_t fc_req;
  tcdm_req_t dbg_req;
  tcdm_rsp_t fc_rsp;
  tcdm_rsp_t dbg_rsp;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      dmactive;
  logic      ndmreset;
  logic      debug_req;

  string       cur_test;
  int unsigned n_checks;
  int unsigned err_tcdm;
  int unsigned err_apb;
  int unsigned err_level;
  int unsigned err_proto;
  int unsigned err_total;
  int unsigned cycle_cnt;
  integer      seed;

  tb_clk_gen clk_gen_i (
    .clk_o  (s_soc_clk),
    .rstn_o (s_soc_rstn)
  );

  soc_domain soc_domain_i (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .fc_req_i    (fc_req),
    .dbg_req_i   (dbg_req),
    .fc_rsp_o    (fc_rsp),
    .dbg_rsp_o   (dbg_rsp),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .dmactive_o  (dmactive),
    .ndmreset_o  (ndmreset),
    .debug_req_o (debug_req)
  );

  // ************************************************************
  // compare tasks
  // ************************************************************
  task automatic check_tcdm(input string name, input tcdm_rsp_t act, input logic [31:0] exp);
    n_checks++;
    if (act.r_rdata !== exp) begin
      err_tcdm++;
      $display("ERROR %s %s: expected %h, actual %h", cur_test, name, exp, act.r_rdata);
    end
  endtask

  task automatic check_apb(input string name, input apb_rsp_t act, input logic [31:0] exp);
    n_checks++;
    if (act.prdata !== exp) begin
      err_apb++;
      $display("ERROR %s %s: expected %h, actual %h", cur_test, name, exp, act.prdata);
    end
  endtask

  task automatic check_level(input string name, input logic act, input logic exp);
    n_checks++;
    if (act !== exp) begin
      err_level++;
      $display("ERROR %s %s: expected %b, actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic expect_cycles(input string name, input int unsigned act, input int unsigned exp);
    n_checks++;
    if (act != exp) begin
      err_proto++;
      $display("ERROR %s %s: expected %0d, actual %0d", cur_test, name, exp, act);
    end
  endtask

  task automatic protocol_fail(input string what);
    err_proto++;
    $display("handshake failure in %s: %s", cur_test, what);
  endtask

  // ************************************************************
  // bus drivers
  // ************************************************************
  function automatic tcdm_req_t make_req(input logic we, input logic [3:0] be,
                                         input logic [31:0] addr, input logic [31:0] wdata);
    tcdm_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // master 0 is the fc port and master 1 the debug port
  task automatic drive_master(input int m, input tcdm_req_t r);
    if (m == 0) begin
      fc_req = r;
    end else begin
      dbg_req = r;
    end
  endtask

  function automatic tcdm_rsp_t master_rsp(input int m);
    return (m == 0) ? fc_rsp : dbg_rsp;
  endfunction

  // one request held until gnt while waited counts falling edges to the grant
  task automatic tcdm_xfer(input int m, input logic we, input logic [3:0] be,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           output tcdm_rsp_t rsp, output int unsigned waited);
    @(negedge s_soc_clk);
    drive_master(m, make_req(we, be, addr, wdata));
    waited = 0;
    rsp    = '0;
    while (!rsp.gnt && waited < WAIT_MAX) begin
      @(negedge s_soc_clk);
      waited++;
      // gnt seen here was up at the last rising edge so r_valid follows it now
      rsp = master_rsp(m);
    end
    if (!rsp.gnt) begin
      protocol_fail($sformatf("master %0d got no gnt for address %h", m, addr));
    end else if (!rsp.r_valid) begin
      protocol_fail($sformatf("master %0d saw no r_valid after gnt at %h", m, addr));
    end
    drive_master(m, '0);
  endtask

  // setup cycle then access held until pready while cycles counts the access phase
  task automatic apb_xfer(input logic we, input logic [11:0] addr, input logic [31:0] wdata,
                          output apb_rsp_t rsp, output int unsigned cycles);
    @(negedge s_soc_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = we;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge s_soc_clk);
    apb_req.penable = 1'b1;
    cycles = 1;
    rsp    = '0;
    while (!rsp.pready && cycles < WAIT_MAX) begin
      @(negedge s_soc_clk);
      cycles++;
      rsp = apb_rsp;
    end
    if (!rsp.pready) begin
      protocol_fail($sformatf("apb access at %h never saw pready", addr));
    end
    // access completes on the coming rising edge
    @(negedge s_soc_clk);
    apb_req = '0;
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************
  task automatic debug_level_test();
    apb_rsp_t    rsp;
    int unsigned cyc;
    cur_test = "debug_level_test";
    check_level("dmactive after reset", dmactive, 1'b0);
    check_level("ndmreset after reset", ndmreset, 1'b0);
    check_level("debug_req after reset", debug_req, 1'b0);
    // ndmreset alone while the dm is inactive
    apb_xfer(1'b1, DBG_DMCONTROL_OFFS, 32'h0000_0002, rsp, cyc);
    check_level("ndmreset without dmactive", ndmreset, 1'b0);
    check_level("dmactive left low", dmactive, 1'b0);
    // dmactive, ndmreset and haltreq together
    apb_xfer(1'b1, DBG_DMCONTROL_OFFS, 32'h0000_0007, rsp, cyc);
    check_level("dmactive set", dmactive, 1'b1);
    check_level("ndmreset set", ndmreset, 1'b1);
    check_level("debug_req set", debug_req, 1'b1);
    apb_xfer(1'b0, DBG_DMCONTROL_OFFS, 32'h0, rsp, cyc);
    check_apb("dmcontrol readback", rsp, 32'h0000_0007);
    // clear all while still active
    apb_xfer(1'b1, DBG_DMCONTROL_OFFS, 32'h0, rsp, cyc);
    check_level("dmactive cleared", dmactive, 1'b0);
    check_level("ndmreset cleared", ndmreset, 1'b0);
    check_level("debug_req cleared", debug_req, 1'b0);
  endtask

  task automatic apb_access_test();
    apb_rsp_t    rsp;
    int unsigned cyc;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] hartinfo;
    cur_test = "apb_access_test";
    d0 = $random(seed);
    d1 = $random(seed);
    // nscratch 23:20, dataaccess 16, datasize 15:12, dataaddr 11:0
    hartinfo = (32'd2 << 20) | (32'd1 << 16) | (32'd2 << 12) | 32'h380;
    apb_xfer(1'b1, DBG_DATA0_OFFS, d0, rsp, cyc);
    expect_cycles("apb write data0 access length", cyc, 2);
    apb_xfer(1'b1, DBG_DATA1_OFFS, d1, rsp, cyc);
    expect_cycles("apb write data1 access length", cyc, 2);
    apb_xfer(1'b0, DBG_DATA0_OFFS, 32'h0, rsp, cyc);
    check_apb("data0 readback", rsp, d0);
    expect_cycles("apb read data0 access length", cyc, 2);
    apb_xfer(1'b0, DBG_DATA1_OFFS, 32'h0, rsp, cyc);
    check_apb("data1 readback", rsp, d1);
    apb_xfer(1'b0, DBG_HARTINFO_OFFS, 32'h0, rsp, cyc);
    check_apb("hartinfo", rsp, hartinfo);
    check_level("pslverr", rsp.pslverr, 1'b0);
  endtask

  task automatic l2_interleave_test();
    logic [31:0] words [16];
    logic [31:0] base;
    logic [31:0] bdata;
    logic [31:0] exp;
    tcdm_rsp_t   rsp;
    int unsigned w;
    cur_test = "l2_interleave_test";
    base = L2_BASE + 32'h100;
    // 16 consecutive words spread over all four banks
    for (int unsigned i = 0; i < 16; i++) begin
      words[i] = $random(seed);
      tcdm_xfer(0, 1'b1, 4'hF, base + 4 * i, words[i], rsp, w);
    end
    for (int unsigned i = 0; i < 16; i++) begin
      tcdm_xfer(1, 1'b0, 4'h0, base + 4 * i, 32'h0, rsp, w);
      check_tcdm($sformatf("l2 word %0d", i), rsp, words[i]);
    end
    // lanes 0 and 2 of word 5
    bdata = $random(seed);
    tcdm_xfer(0, 1'b1, 4'b0101, base + 20, bdata, rsp, w);
    exp = (words[5] & 32'hFF00_FF00) | (bdata & 32'h00FF_00FF);
    tcdm_xfer(1, 1'b0, 4'h0, base + 20, 32'h0, rsp, w);
    check_tcdm("l2 byte enable 0101", rsp, exp);
    // top lane of word 10 written from the debug port
    bdata = $random(seed);
    tcdm_xfer(1, 1'b1, 4'b1000, base + 40, bdata, rsp, w);
    exp = {bdata[31:24], words[10][23:0]};
    tcdm_xfer(0, 1'b0, 4'h0, base + 40, 32'h0, rsp, w);
    check_tcdm("l2 byte enable 1000", rsp, exp);
  endtask

  task automatic rom_read_test();
    tcdm_rsp_t   rsp;
    int unsigned w;
    cur_test = "rom_read_test";
    for (int unsigned i = 0; i < ROM_WORDS; i++) begin
      tcdm_xfer(0, 1'b0, 4'h0, ROM_BASE + 4 * i, 32'h0, rsp, w);
      check_tcdm($sformatf("rom word %0d", i), rsp, BOOT_IMAGE[i]);
    end
    // rom ignores the write but still answers
    tcdm_xfer(1, 1'b1, 4'hF, ROM_BASE + 8, $random(seed), rsp, w);
    tcdm_xfer(0, 1'b0, 4'h0, ROM_BASE + 8, 32'h0, rsp, w);
    check_tcdm("rom word 2 after write", rsp, BOOT_IMAGE[2]);
  endtask

  task automatic unmapped_test();
    tcdm_rsp_t   rsp;
    int unsigned w;
    cur_test = "unmapped_test";
    tcdm_xfer(0, 1'b0, 4'h0, 32'h3000_0000, 32'h0, rsp, w);
    expect_cycles("unmapped read grant wait", w, 1);
    check_tcdm("unmapped read fc", rsp, ERR_RDATA);
    // first word past the end of l2
    tcdm_xfer(1, 1'b0, 4'h0, L2_BASE + L2_SIZE, 32'h0, rsp, w);
    check_tcdm("unmapped read dbg", rsp, ERR_RDATA);
  endtask

  task automatic priority_test();
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    tcdm_rsp_t   f;
    tcdm_rsp_t   d;
    int unsigned w;
    cur_test = "priority_test";
    // a0 and a1 share bank 0 while a2 sits in bank 1
    a0 = L2_BASE + 32'h40;
    a1 = L2_BASE + 32'h50;
    a2 = L2_BASE + 32'h44;
    v0 = $random(seed);
    v1 = $random(seed);
    v2 = $random(seed);
    tcdm_xfer(0, 1'b1, 4'hF, a0, v0, f, w);
    tcdm_xfer(0, 1'b1, 4'hF, a1, v1, f, w);
    tcdm_xfer(0, 1'b1, 4'hF, a2, v2, f, w);
    // same bank in the same cycle
    @(negedge s_soc_clk);
    drive_master(0, make_req(1'b0, 4'h0, a0, 32'h0));
    drive_master(1, make_req(1'b0, 4'h0, a1, 32'h0));
    @(negedge s_soc_clk);
    f = fc_rsp;
    d = dbg_rsp;
    check_level("same bank fc gnt", f.gnt, 1'b1);
    check_level("same bank dbg gnt", d.gnt, 1'b0);
    check_level("same bank fc r_valid", f.r_valid, 1'b1);
    check_level("same bank dbg r_valid", d.r_valid, 1'b0);
    check_tcdm("same bank fc data", f, v0);
    drive_master(0, '0);
    @(negedge s_soc_clk);
    d = dbg_rsp;
    check_level("same bank dbg gnt later", d.gnt, 1'b1);
    check_level("same bank dbg r_valid later", d.r_valid, 1'b1);
    check_tcdm("same bank dbg data", d, v1);
    drive_master(1, '0);
    // different banks granted together in one cycle
    @(negedge s_soc_clk);
    drive_master(0, make_req(1'b0, 4'h0, a0, 32'h0));
    drive_master(1, make_req(1'b0, 4'h0, a2, 32'h0));
    @(negedge s_soc_clk);
    f = fc_rsp;
    d = dbg_rsp;
    check_level("split bank fc gnt", f.gnt, 1'b1);
    check_level("split bank dbg gnt", d.gnt, 1'b1);
    check_level("split bank fc r_valid", f.r_valid, 1'b1);
    check_level("split bank dbg r_valid", d.r_valid, 1'b1);
    check_tcdm("split bank fc data", f, v0);
    check_tcdm("split bank dbg data", d, v2);
    drive_master(0, '0);
    drive_master(1, '0);
  endtask

  // ************************************************************
  // run control
  // ************************************************************
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge s_soc_clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    seed      = 32'hb5a;
    fc_req    = '0;
    dbg_req   = '0;
    apb_req   = '0;
    cur_test  = "reset";
    n_checks  = 0;
    err_tcdm  = 0;
    err_apb   = 0;
    err_level = 0;
    err_proto = 0;
    wait (s_soc_rstn === 1'b1);
    @(negedge s_soc_clk);
    debug_level_test();
    apb_access_test();
    l2_interleave_test();
    rom_read_test();
    unmapped_test();
    priority_test();
    err_total = err_tcdm + err_apb + err_level + err_proto;
    $display("checks %0d, errors %0d (tcdm %0d, apb %0d, level %0d, protocol %0d)",
             n_checks, err_total, err_tcdm, err_apb, err_level, err_proto);
    if (err_total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/soc_interconnect.sv
verilog/l2_ram_bank.sv
verilog/boot_rom.sv
verilog/apb2per.sv
verilog/debug_regs.sv
verilog/soc_domain.sv
sim/tb_clk_gen.sv
sim/tb_soc_domain.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_soc_domain
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
